// File: filelist.f
+incdir+hw
hw/ahb_mem_pkg.sv
hw/ahb_wait_timer.sv
hw/ahb_mem_ctrl.sv
hw/ahb_write_path.sv
hw/ahb_byte_ram.sv
hw/ahb_mem_top.sv
testbench/ahb_mem_props.sv
testbench/tb_ahb_mem.sv

// File: hw/ahb_byte_ram.sv
/* Word-wide RAM with byte write enables and a registered read */
`default_nettype none

`include "ahb_mem_defines.svh"

module ahb_byte_ram
    import ahb_mem_pkg::*;
(
    input  wire            s_clk_i,
    input  wire waddr_t    raddr_i,
    output word_t          rdata_o,
    input  wire waddr_t    waddr_i,
    input  wire bytemask_t be_i,
    input  wire word_t     wdata_i
);

    // Contents start cleared
    word_t r_mem [`MEM_SIZE_BYTES/4] = '{default: '0};
    word_t r_rdata;

    always_ff @(posedge s_clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (be_i[i]) begin
                r_mem[waddr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
            end
        end
    end

    // Old data when reading a word that is written on the same edge
    always_ff @(posedge s_clk_i) begin
        r_rdata <= r_mem[raddr_i];
    end

    assign rdata_o = r_rdata;

endmodule

`default_nettype wire

// File: hw/ahb_mem_ctrl.sv
/* AHB-Lite slave controller, checks requests and runs the data phase
   and the two-cycle ERROR response */
`default_nettype none

`include "ahb_mem_defines.svh"

module ahb_mem_ctrl
    import ahb_mem_pkg::*;
(
    input  wire          s_clk_i,
    input  wire          s_resetn_i,
    input  wire haddr_t  s_haddr_i,
    input  wire hsize_t  s_hsize_i,
    input  wire htrans_t s_htrans_i,
    input  wire          s_hwrite_i,
    input  wire          s_hsel_i,
    input  wire          s_hready_i,
    input  wire          timer_done_i,
    output logic         accept_o,
    output logic         legal_o,
    output logic         timer_start_o,
    output logic         commit_o,
    output logic         s_hready_o,
    output logic         s_hresp_o
);

    ctrl_state_t r_state;
    ctrl_state_t s_next;
    logic        r_write;
    logic        s_in_range;
    logic        s_aligned;

    // NONSEQ and SEQ both have bit 1 set, BUSY counts as IDLE
    assign accept_o = s_hsel_i & s_htrans_i[1] & s_hready_i & s_hready_o;

    assign s_in_range = (s_haddr_i < haddr_t'(`MEM_SIZE_BYTES));

    // Sizes above a word are never aligned
    always_comb begin
        case (s_hsize_i)
            3'd0:    s_aligned = 1'b1;
            3'd1:    s_aligned = ~s_haddr_i[0];
            3'd2:    s_aligned = (s_haddr_i[1:0] == 2'b00);
            default: s_aligned = 1'b0;
        endcase
    end

    assign legal_o       = s_in_range & s_aligned;
    assign timer_start_o = accept_o & legal_o;

    // Bus response follows the state directly
    always_comb begin
        case (r_state)
            DATA: begin
                s_hready_o = timer_done_i;
                s_hresp_o  = 1'b0;
            end
            ERR_FIRST: begin
                s_hready_o = 1'b0;
                s_hresp_o  = 1'b1;
            end
            ERR_SECOND: begin
                s_hready_o = 1'b1;
                s_hresp_o  = 1'b1;
            end
            default: begin
                s_hready_o = 1'b1;
                s_hresp_o  = 1'b0;
            end
        endcase
    end

    always_comb begin
        s_next = r_state;
        if (accept_o) begin
            s_next = legal_o ? DATA : ERR_FIRST;
        end else begin
            case (r_state)
                DATA: begin
                    if (timer_done_i) begin
                        s_next = IDLE;
                    end
                end
                ERR_FIRST:  s_next = ERR_SECOND;
                default:    s_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            r_state <= IDLE;
            r_write <= 1'b0;
        end else begin
            r_state <= s_next;
            if (accept_o) begin
                r_write <= s_hwrite_i & legal_o;
            end
        end
    end

    // Last data-phase cycle of a legal write
    assign commit_o = (r_state == DATA) & r_write & timer_done_i;

endmodule

`default_nettype wire

// File: hw/ahb_mem_defines.svh
/* Build-time configuration of the AHB-Lite memory slave */

`ifndef AHB_MEM_DEFINES_SVH
`define AHB_MEM_DEFINES_SVH

// Memory size in bytes, must be a power of two
`define MEM_SIZE_BYTES 4096

// Byte address width inside the memory
`define MEM_ADDR_W 12

// Wait states per transfer, 0 to 3
`define MEM_WAIT_STATES 1

`endif

// File: hw/ahb_mem_pkg.sv
/* Shared types of the AHB-Lite memory slave
   Bus vectors and the controller states */
`default_nettype none

`include "ahb_mem_defines.svh"

package ahb_mem_pkg;

    // AHB byte address and data word
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] word_t;

    // Word index into the RAM
    typedef logic [`MEM_ADDR_W-3:0] waddr_t;

    // Transfer size and type as on the bus
    typedef logic [2:0] hsize_t;
    typedef logic [1:0] htrans_t;

    typedef logic [3:0] bytemask_t;
    typedef logic [1:0] wait_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        ERR_FIRST,
        ERR_SECOND
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/ahb_mem_top.sv
/* AHB-Lite memory slave, controller, wait timer, write path and RAM */
`default_nettype none

module ahb_mem_top
    import ahb_mem_pkg::*;
(
    input  wire          s_clk_i,
    input  wire          s_resetn_i,
    input  wire haddr_t  s_haddr_i,
    input  wire word_t   s_hwdata_i,
    input  wire hsize_t  s_hsize_i,
    input  wire htrans_t s_htrans_i,
    input  wire          s_hwrite_i,
    input  wire          s_hsel_i,
    input  wire          s_hready_i,
    output word_t        s_hrdata_o,
    output logic         s_hready_o,
    output logic         s_hresp_o
);

    logic      s_accept;
    logic      s_legal;
    logic      s_timer_start;
    logic      s_timer_done;
    logic      s_commit;
    waddr_t    s_ram_raddr;
    waddr_t    s_ram_waddr;
    bytemask_t s_ram_be;
    word_t     s_ram_wdata;
    word_t     s_ram_rdata;

    ahb_mem_ctrl i_ctrl (
        .s_clk_i       (s_clk_i),
        .s_resetn_i    (s_resetn_i),
        .s_haddr_i     (s_haddr_i),
        .s_hsize_i     (s_hsize_i),
        .s_htrans_i    (s_htrans_i),
        .s_hwrite_i    (s_hwrite_i),
        .s_hsel_i      (s_hsel_i),
        .s_hready_i    (s_hready_i),
        .timer_done_i  (s_timer_done),
        .accept_o      (s_accept),
        .legal_o       (s_legal),
        .timer_start_o (s_timer_start),
        .commit_o      (s_commit),
        .s_hready_o    (s_hready_o),
        .s_hresp_o     (s_hresp_o)
    );

    ahb_wait_timer i_timer (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .start_i    (s_timer_start),
        .done_o     (s_timer_done)
    );

    ahb_write_path i_write_path (
        .s_clk_i     (s_clk_i),
        .s_resetn_i  (s_resetn_i),
        .s_haddr_i   (s_haddr_i),
        .s_hsize_i   (s_hsize_i),
        .s_hwrite_i  (s_hwrite_i),
        .s_hwdata_i  (s_hwdata_i),
        .accept_i    (s_accept),
        .legal_i     (s_legal),
        .commit_i    (s_commit),
        .ram_rdata_i (s_ram_rdata),
        .ram_raddr_o (s_ram_raddr),
        .ram_waddr_o (s_ram_waddr),
        .ram_be_o    (s_ram_be),
        .ram_wdata_o (s_ram_wdata),
        .s_hrdata_o  (s_hrdata_o)
    );

    ahb_byte_ram i_ram (
        .s_clk_i (s_clk_i),
        .raddr_i (s_ram_raddr),
        .rdata_o (s_ram_rdata),
        .waddr_i (s_ram_waddr),
        .be_i    (s_ram_be),
        .wdata_i (s_ram_wdata)
    );

endmodule

`default_nettype wire

// File: hw/ahb_wait_timer.sv
/* Wait-state timer, holds each data phase for a fixed number of cycles */
`default_nettype none

`include "ahb_mem_defines.svh"

module ahb_wait_timer
    import ahb_mem_pkg::*;
(
    input  wire  s_clk_i,
    input  wire  s_resetn_i,
    input  wire  start_i,
    output logic done_o
);

    wait_cnt_t r_count;

    // Reload on each legal accept, then run down to zero
    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            r_count <= '0;
        end else if (start_i) begin
            r_count <= wait_cnt_t'(`MEM_WAIT_STATES);
        end else if (r_count != '0) begin
            r_count <= r_count - 1'b1;
        end
    end

    // With no wait states the count never leaves zero
    assign done_o = (r_count == '0);

endmodule

`default_nettype wire

// File: hw/ahb_write_path.sv
/* Write path of the memory slave, byte lanes, RAM addressing
   and forwarding of the last written word */
`default_nettype none

`include "ahb_mem_defines.svh"

module ahb_write_path
    import ahb_mem_pkg::*;
(
    input  wire          s_clk_i,
    input  wire          s_resetn_i,
    input  wire haddr_t  s_haddr_i,
    input  wire hsize_t  s_hsize_i,
    input  wire          s_hwrite_i,
    input  wire word_t   s_hwdata_i,
    input  wire          accept_i,
    input  wire          legal_i,
    input  wire          commit_i,
    input  wire word_t   ram_rdata_i,
    output waddr_t       ram_raddr_o,
    output waddr_t       ram_waddr_o,
    output bytemask_t    ram_be_o,
    output word_t        ram_wdata_o,
    output word_t        s_hrdata_o
);

    logic       s_capture;
    waddr_t     r_waddr;
    logic [1:0] r_lane;
    logic [1:0] r_size;
    logic       r_write;
    bytemask_t  s_lanes;
    logic       r_fwd_valid;
    waddr_t     r_fwd_waddr;
    word_t      r_fwd_data;
    word_t      s_merged;

    assign s_capture = accept_i & legal_i;

    // Attributes of the transfer in its data phase
    always_ff @(posedge s_clk_i) begin
        if (s_capture) begin
            r_waddr <= s_haddr_i[`MEM_ADDR_W-1:2];
            r_lane  <= s_haddr_i[1:0];
            r_size  <= s_hsize_i[1:0];
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            r_write <= 1'b0;
        end else if (s_capture) begin
            r_write <= s_hwrite_i;
        end
    end

    always_comb begin
        case (r_size)
            2'd0:    s_lanes = bytemask_t'(4'b0001 << r_lane);
            2'd1:    s_lanes = r_lane[1] ? 4'b1100 : 4'b0011;
            default: s_lanes = 4'b1111;
        endcase
    end

    assign ram_be_o    = (commit_i & r_write) ? s_lanes : '0;
    assign ram_waddr_o = r_waddr;
    assign ram_wdata_o = s_hwdata_i;

    // Read is issued in the address phase, then held on the data-phase word
    assign ram_raddr_o = accept_i ? s_haddr_i[`MEM_ADDR_W-1:2] : r_waddr;

    // RAM output lags a commit on the same edge, so serve the saved copy
    assign s_hrdata_o = (r_fwd_valid && (r_fwd_waddr == r_waddr)) ? r_fwd_data : ram_rdata_i;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            s_merged[i*8 +: 8] = ram_be_o[i] ? s_hwdata_i[i*8 +: 8] : s_hrdata_o[i*8 +: 8];
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            r_fwd_valid <= 1'b0;
        end else if (commit_i) begin
            r_fwd_valid <= 1'b1;
        end else if (s_capture) begin
            r_fwd_valid <= 1'b0;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (commit_i) begin
            r_fwd_waddr <= r_waddr;
            r_fwd_data  <= s_merged;
        end
    end

endmodule

`default_nettype wire

// File: testbench/ahb_mem_props.sv
/* AHB response rules of the memory slave as bound assertions */
`default_nettype none

module ahb_mem_props
    import ahb_mem_pkg::*;
(
    input wire            s_clk_i,
    input wire            s_resetn_i,
    input wire            s_hready_o,
    input wire            s_hresp_o,
    input wire bytemask_t s_ram_be
);

    int n_fail = 0;

    // First ERROR cycle is followed by the second with hready high
    a_err_two_cycles: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        (s_hresp_o && !s_hready_o) |=> (s_hresp_o && s_hready_o))
        else begin
            $error("ERROR response did not finish in its second cycle");
            n_fail++;
        end

    a_err_starts_low: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        (s_hresp_o && s_hready_o) |-> $past(s_hresp_o && !s_hready_o))
        else begin
            $error("ERROR response without a first cycle with hready low");
            n_fail++;
        end

    a_reset_quiet: assert property (@(posedge s_clk_i)
        !s_resetn_i |=> (!s_hresp_o && s_hready_o))
        else begin
            $error("Response not idle after reset");
            n_fail++;
        end

    a_no_write_on_err: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
        s_hresp_o |-> (s_ram_be == '0))
        else begin
            $error("Byte enable active during an ERROR response");
            n_fail++;
        end

endmodule

bind ahb_mem_top ahb_mem_props i_props (
    .s_clk_i    (s_clk_i),
    .s_resetn_i (s_resetn_i),
    .s_hready_o (s_hready_o),
    .s_hresp_o  (s_hresp_o),
    .s_ram_be   (s_ram_be)
);

`default_nettype wire

// File: testbench/tb_ahb_mem.sv
/* Testbench of the AHB-Lite memory slave, random master against a byte model */
`default_nettype none

`include "ahb_mem_defines.svh"

module tb_ahb_mem
    import ahb_mem_pkg::*;
;

    localparam int N_XFERS  = 600;
    localparam int W        = `MEM_WAIT_STATES;
    localparam int WD_LIMIT = N_XFERS * (W + 3) + 3 + 8;

    logic    s_clk;
    logic    s_resetn;
    haddr_t  s_haddr;
    word_t   s_hwdata;
    hsize_t  s_hsize;
    htrans_t s_htrans;
    logic    s_hwrite;
    logic    s_hsel;
    logic    s_hready_in;
    word_t   s_hrdata;
    logic    s_hready;
    logic    s_hresp;

    integer  seed = 32'hf1d84e15;
    haddr_t  last_addr = '0;
    logic [7:0] model_mem [`MEM_SIZE_BYTES];

    ahb_mem_top i_ahb_mem_top (
        .s_clk_i    (s_clk),
        .s_resetn_i (s_resetn),
        .s_haddr_i  (s_haddr),
        .s_hwdata_i (s_hwdata),
        .s_hsize_i  (s_hsize),
        .s_htrans_i (s_htrans),
        .s_hwrite_i (s_hwrite),
        .s_hsel_i   (s_hsel),
        .s_hready_i (s_hready_in),
        .s_hrdata_o (s_hrdata),
        .s_hready_o (s_hready),
        .s_hresp_o  (s_hresp)
    );

    initial begin
        s_clk = 1'b0;
        forever #50 s_clk = ~s_clk;
    end

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic is_legal(input haddr_t a, input hsize_t sz);
        if (sz > 3'd2) begin
            return 1'b0;
        end
        return (a < `MEM_SIZE_BYTES) && ((a % (1 << sz)) == 0);
    endfunction

    // Byte lanes touched by a transfer, AHB little-endian lane order
    function automatic word_t lane_mask(input haddr_t a, input hsize_t sz);
        word_t m;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            if (i >= a[1:0] && i < a[1:0] + (1 << sz)) begin
                m[i*8 +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    function automatic word_t model_word(input haddr_t a);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[i*8 +: 8] = model_mem[{a[`MEM_ADDR_W-1:2], 2'b00} + i];
        end
        return w;
    endfunction

    task automatic model_write(input haddr_t a, input hsize_t sz, input word_t wd);
        word_t m;
        m = lane_mask(a, sz);
        for (int i = 0; i < 4; i++) begin
            if (m[i*8]) begin
                model_mem[{a[`MEM_ADDR_W-1:2], 2'b00} + i] = wd[i*8 +: 8];
            end
        end
    endtask

    // About 5 % out of range, 4 % misaligned, 1 % oversized, the rest legal
    task automatic pick_request(output haddr_t a, output hsize_t sz, output logic wr,
                                output word_t wd);
        logic [31:0] r;
        logic [31:0] v;
        r  = {$random(seed)} % 100;
        v  = $random(seed);
        wr = v[0];
        wd = $random(seed);
        sz = hsize_t'(v[7:4] % 3);
        if (r < 5) begin
            a = (`MEM_SIZE_BYTES + ({$random(seed)} % 8192)) & ~((1 << sz) - 1);
        end else if (r < 9) begin
            sz = v[1] ? 3'd2 : 3'd1;
            a  = {$random(seed)} % `MEM_SIZE_BYTES;
            a[0] = 1'b1;
        end else if (r < 10) begin
            sz = 3'd3;
            a  = ({$random(seed)} % `MEM_SIZE_BYTES) & ~32'h7;
        end else begin
            // Reuse the last word often so reads follow writes to it
            if (v[3:2] == 2'b00) begin
                a = {last_addr[31:2], v[9:8]};
            end else if (v[3:2] == 2'b01) begin
                a = {$random(seed)} % 64;
            end else begin
                a = {$random(seed)} % `MEM_SIZE_BYTES;
            end
            a = a & ~((1 << sz) - 1);
            last_addr = a;
        end
    endtask

    initial begin : stimulus
        int          issued;
        int          gap;
        int          dp_cnt;
        logic        dp_active;
        logic        dp_legal;
        logic        dp_write;
        logic        dp_done;
        haddr_t      dp_addr;
        hsize_t      dp_size;
        word_t       dp_wdata;
        logic        ap_active;
        logic        ap_write;
        haddr_t      ap_addr;
        hsize_t      ap_size;
        word_t       ap_wdata;
        logic        exp_ready;
        logic        exp_resp;
        word_t       mask;
        logic [31:0] v;
        for (int i = 0; i < `MEM_SIZE_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        s_resetn    = 1'b0;
        s_haddr     = '0;
        s_hwdata    = '0;
        s_hsize     = '0;
        s_htrans    = 2'b00;
        s_hwrite    = 1'b0;
        s_hsel      = 1'b0;
        s_hready_in = 1'b1;
        issued      = 0;
        gap         = 0;
        dp_cnt      = 0;
        dp_active   = 1'b0;
        ap_active   = 1'b0;
        repeat (3) @(posedge s_clk);
        s_resetn <= 1'b1;
        while (issued < N_XFERS || ap_active || dp_active) begin
            // Mid-cycle check of the data phase in flight
            @(negedge s_clk);
            exp_ready = 1'b1;
            exp_resp  = 1'b0;
            if (dp_active) begin
                if (dp_legal) begin
                    exp_ready = (dp_cnt == W);
                end else begin
                    exp_resp  = 1'b1;
                    exp_ready = (dp_cnt == 1);
                end
            end
            dp_done = dp_active && exp_ready;
            check_resp("s_hready_o", s_hready, exp_ready);
            check_resp("s_hresp_o", s_hresp, exp_resp);
            // Bound assertions count their failures
            if (i_ahb_mem_top.i_props.n_fail != 0) begin
                $display("A bound assertion failed before t=%0t", $time);
                stop_on_error();
            end
            if (dp_done && dp_legal) begin
                mask = lane_mask(dp_addr, dp_size);
                if (dp_write) begin
                    model_write(dp_addr, dp_size, dp_wdata);
                end else begin
                    check_word("s_hrdata_o", s_hrdata & mask, model_word(dp_addr) & mask);
                end
            end

            @(posedge s_clk);
            dp_cnt++;
            if (dp_done) begin
                dp_active = 1'b0;
            end
            if (ap_active && exp_ready) begin
                dp_active = 1'b1;
                dp_cnt    = 0;
                dp_legal  = is_legal(ap_addr, ap_size);
                dp_write  = ap_write;
                dp_addr   = ap_addr;
                dp_size   = ap_size;
                dp_wdata  = ap_wdata;
                ap_active = 1'b0;
                s_hwdata  <= ap_write ? ap_wdata : word_t'($random(seed));
                v   = $random(seed);
                gap = (v[2:0] < 3'd5) ? 0 : 1 + v[3];
            end
            if (!ap_active) begin
                if (gap == 0 && issued < N_XFERS) begin
                    pick_request(ap_addr, ap_size, ap_write, ap_wdata);
                    ap_active = 1'b1;
                    issued++;
                end else if (gap > 0) begin
                    gap--;
                end
            end
            v = $random(seed);
            if (ap_active) begin
                s_hsel   <= 1'b1;
                s_htrans <= {1'b1, v[0]};
                s_haddr  <= ap_addr;
                s_hsize  <= ap_size;
                s_hwrite <= ap_write;
            end else begin
                // Idle cycles mix IDLE, BUSY and deselected requests
                s_hsel   <= v[0];
                s_htrans <= v[0] ? {1'b0, v[1]} : v[2:1];
                s_haddr  <= $random(seed);
                s_hsize  <= v[5:3];
                s_hwrite <= v[6];
            end
        end
        if (i_ahb_mem_top.i_props.n_fail == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", i_ahb_mem_top.i_props.n_fail);
            $display("ERRORS FOUND");
            $fatal(1, "Assertion failures during the run");
        end
    end

    initial begin : watchdog
        #(WD_LIMIT * 100);
        $display("Timeout: the transfers did not complete in the expected time");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
